/* source/rp_pkg.sv */
package rp_pkg;

//////////////////////////////////////////////////////////////////////
// system bus
//////////////////////////////////////////////////////////////////////

typedef logic [32-1:0] sys_addr_t;  // byte address
typedef logic [32-1:0] sys_data_t;  // read and write data
typedef logic [ 3-1:0] region_t;    // one of 8 regions

// address map, 2^20 bytes per region
localparam int unsigned SYS_REGION_LSB = 20;

localparam region_t REGION_HK  = 3'd0;  // housekeeping
localparam region_t REGION_ADC = 3'd1;  // sample readback
localparam region_t REGION_AMS = 3'd2;  // pdm settings
// regions 3..7 unmapped, the decoder answers them with err

//////////////////////////////////////////////////////////////////////
// converter
//////////////////////////////////////////////////////////////////////

typedef logic        [14-1:0] adc_raw_t;     // offset binary, negative slope
typedef logic signed [14-1:0] adc_sample_t;  // two's complement

//////////////////////////////////////////////////////////////////////
// housekeeping and analog mixed signals
//////////////////////////////////////////////////////////////////////

typedef logic [8-1:0] led_t;
typedef logic [8-1:0] pdm_cfg_t;  // ones per PDM_RANGE cycles

localparam sys_data_t HK_ID = 32'h52500004;  // read only id word

// modulator period in cycles
localparam int unsigned PDM_RANGE = 255;

endpackage: rp_pkg

/* source/sys_bus_if.sv */
`timescale 1ns/1ps

interface sys_bus_if
  import rp_pkg::*;
();

  sys_addr_t addr;   // full byte address, region in [22:20]
  sys_data_t wdata;  // write data
  logic      wen;    // one cycle write strobe
  logic      ren;    // one cycle read strobe
  sys_data_t rdata;  // valid together with ack
  logic      err;    // valid together with ack
  logic      ack;    // exactly one cycle after wen/ren

  // request side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, err, ack
  );

  // response side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, err, ack
  );

endinterface: sys_bus_if

/* source/sys_bus_decoder.sv */
`timescale 1ns/1ps

module sys_bus_decoder
  import rp_pkg::*;
(
  input  logic       adc_clk_01,
  input  logic       rst_i,
  sys_bus_if.slave   bus_up,    // upstream master
  sys_bus_if.master  bus_hk,    // region 0
  sys_bus_if.master  bus_adc,   // region 1
  sys_bus_if.master  bus_ams    // region 2
);

localparam int unsigned DW = $bits(sys_data_t);

region_t region;   // address bits [22:20]
logic    req;      // any request this cycle
logic    mapped;   // region has a slave
logic    unm_ack;  // own answer for unmapped regions

assign region = bus_up.addr[SYS_REGION_LSB +: $bits(region_t)];
assign req    = bus_up.wen | bus_up.ren;
assign mapped = (region == REGION_HK) | (region == REGION_ADC) | (region == REGION_AMS);

//////////////////////////////////////////////////////////////////////
// request fan out
//////////////////////////////////////////////////////////////////////

// slaves keep the full address and decode [3:2] themselves
assign bus_hk.addr   = bus_up.addr;
assign bus_hk.wdata  = bus_up.wdata;
assign bus_adc.addr  = bus_up.addr;
assign bus_adc.wdata = bus_up.wdata;
assign bus_ams.addr  = bus_up.addr;
assign bus_ams.wdata = bus_up.wdata;

// strobes only to the selected region
assign bus_hk.wen  = bus_up.wen & (region == REGION_HK);
assign bus_hk.ren  = bus_up.ren & (region == REGION_HK);
assign bus_adc.wen = bus_up.wen & (region == REGION_ADC);
assign bus_adc.ren = bus_up.ren & (region == REGION_ADC);
assign bus_ams.wen = bus_up.wen & (region == REGION_AMS);
assign bus_ams.ren = bus_up.ren & (region == REGION_AMS);

// unmapped: ack with err one cycle later, rdata stays zero
always_ff @(posedge adc_clk_01) begin
  if (rst_i) begin
    unm_ack <= 1'b0;
  end else begin
    unm_ack <= req & ~mapped;
  end
end

//////////////////////////////////////////////////////////////////////
// response merge, only the addressed region can ack
//////////////////////////////////////////////////////////////////////

assign bus_up.ack = bus_hk.ack | bus_adc.ack | bus_ams.ack | unm_ack;

assign bus_up.err = (bus_hk.ack  & bus_hk.err ) |
                    (bus_adc.ack & bus_adc.err) |
                    (bus_ams.ack & bus_ams.err) |
                    unm_ack;

assign bus_up.rdata = ({DW{bus_hk.ack }} & bus_hk.rdata ) |
                      ({DW{bus_adc.ack}} & bus_adc.rdata) |
                      ({DW{bus_ams.ack}} & bus_ams.rdata);  // zero when unmapped

// every ack answers the request of the previous cycle
ack_after_req: assert property (@(posedge adc_clk_01) disable iff (rst_i)
  bus_up.ack |-> $past(req));

endmodule: sys_bus_decoder

/* source/adc_frontend.sv */
`timescale 1ns/1ps

module adc_frontend
  import rp_pkg::*;
#(
  parameter int unsigned NUM_CH = 4  // 1..4, word offsets 0..3
)(
  input  logic                      adc_clk_01,
  input  logic                      rst_i,
  input  adc_raw_t    [NUM_CH-1:0]  adc_raw_i,
  output adc_sample_t [NUM_CH-1:0]  adc_dat_o,
  sys_bus_if.slave                  bus         // readback, region 1
);

localparam int unsigned RW = $bits(adc_raw_t);
localparam int unsigned SW = $bits(adc_sample_t);
localparam int unsigned DW = $bits(sys_data_t);

adc_sample_t [NUM_CH-1:0] adc_dat_r;  // first stage
adc_sample_t              rd_smp;     // sample picked by offset
logic        [2-1:0]      rd_idx;     // word offset

//////////////////////////////////////////////////////////////////////
// format conversion
//////////////////////////////////////////////////////////////////////

// keep msb, invert the rest, then one more register stage
always_ff @(posedge adc_clk_01) begin
  if (rst_i) begin
    adc_dat_r <= '0;
    adc_dat_o <= '0;
  end else begin
    for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
      adc_dat_r[ch] <= {adc_raw_i[ch][RW-1], ~adc_raw_i[ch][RW-2:0]};
      adc_dat_o[ch] <= adc_dat_r[ch];
    end
  end
end

//////////////////////////////////////////////////////////////////////
// bus readback
//////////////////////////////////////////////////////////////////////

assign rd_idx = bus.addr[3:2];

// offsets beyond NUM_CH read zero
always_comb begin
  rd_smp = '0;
  for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
    if (rd_idx == ch) begin
      rd_smp = adc_dat_o[ch];
    end
  end
end

always_ff @(posedge adc_clk_01) begin
  if (rst_i) begin
    bus.ack <= 1'b0;
  end else begin
    bus.ack <= bus.wen | bus.ren;  // writes acked and dropped
  end
end

always_ff @(posedge adc_clk_01) begin
  bus.rdata <= {{(DW-SW){rd_smp[SW-1]}}, rd_smp};  // sign extend
end

assign bus.err = 1'b0;

endmodule: adc_frontend

/* source/hk_regs.sv */
`timescale 1ns/1ps

module hk_regs
  import rp_pkg::*;
(
  input  logic      adc_clk_01,
  input  logic      rst_i,
  sys_bus_if.slave  bus,         // region 0
  output led_t      led_o
);

// word offsets
localparam logic [2-1:0] OFS_ID  = 2'd0;  // read only
localparam logic [2-1:0] OFS_LED = 2'd1;  // read/write

led_t         led;  // led register
logic [2-1:0] ofs;

assign ofs = bus.addr[3:2];

//////////////////////////////////////////////////////////////////////
// write side
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk_01) begin
  if (rst_i) begin
    led     <= '0;
    bus.ack <= 1'b0;
  end else begin
    bus.ack <= bus.wen | bus.ren;
    if (bus.wen && (ofs == OFS_LED)) begin
      led <= bus.wdata[$bits(led_t)-1:0];  // other offsets ignored
    end
  end
end

assign led_o = led;

//////////////////////////////////////////////////////////////////////
// read side
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk_01) begin
  case (ofs)
    OFS_ID:  bus.rdata <= HK_ID;
    OFS_LED: bus.rdata <= sys_data_t'(led);  // zero extended
    default: bus.rdata <= '0;
  endcase
end

assign bus.err = 1'b0;

endmodule: hk_regs

/* source/ams_pdm.sv */
`timescale 1ns/1ps

module ams_pdm
  import rp_pkg::*;
#(
  parameter int unsigned NUM_CH = 4  // 1..4, word offsets 0..3
)(
  input  logic              adc_clk_01,
  input  logic              rst_i,
  sys_bus_if.slave          bus,        // region 2
  output logic [NUM_CH-1:0] pdm_o       // first order pdm bits
);

localparam int unsigned SUM_W = $bits(pdm_cfg_t) + 1;  // acc + cfg can reach 509

pdm_cfg_t  [NUM_CH-1:0]             cfg;     // density settings
pdm_cfg_t  [NUM_CH-1:0]             acc;     // residue, below PDM_RANGE
logic      [NUM_CH-1:0] [SUM_W-1:0] sum;
logic      [2-1:0]                  ofs;
sys_data_t                          rd_cfg;

assign ofs = bus.addr[3:2];

//////////////////////////////////////////////////////////////////////
// setting registers
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk_01) begin
  if (rst_i) begin
    cfg     <= '0;
    bus.ack <= 1'b0;
  end else begin
    bus.ack <= bus.wen | bus.ren;
    for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
      if (bus.wen && (ofs == ch)) begin
        cfg[ch] <= bus.wdata[$bits(pdm_cfg_t)-1:0];
      end
    end
  end
end

always_comb begin
  rd_cfg = '0;  // unused offsets
  for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
    if (ofs == ch) begin
      rd_cfg = sys_data_t'(cfg[ch]);
    end
  end
end

always_ff @(posedge adc_clk_01) begin
  bus.rdata <= rd_cfg;
end

assign bus.err = 1'b0;

//////////////////////////////////////////////////////////////////////
// modulator
//////////////////////////////////////////////////////////////////////

always_comb begin
  for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
    sum[ch] = SUM_W'(acc[ch]) + SUM_W'(cfg[ch]);
  end
end

// overflow past the range emits a one, the rest carries over
always_ff @(posedge adc_clk_01) begin
  if (rst_i) begin
    acc   <= '0;
    pdm_o <= '0;
  end else begin
    for (int unsigned ch = 0; ch < NUM_CH; ch++) begin
      if (sum[ch] >= PDM_RANGE) begin
        pdm_o[ch] <= 1'b1;
        acc[ch]   <= pdm_cfg_t'(sum[ch] - PDM_RANGE);
      end else begin
        pdm_o[ch] <= 1'b0;
        acc[ch]   <= pdm_cfg_t'(sum[ch]);
      end
    end
  end
end

// exact density per window needs the residue to stay in range
for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_acc_chk
  acc_in_range: assert property (@(posedge adc_clk_01) disable iff (rst_i)
    acc[ch] < PDM_RANGE);
end

endmodule: ams_pdm

/* source/rp_top_4adc.sv */
`timescale 1ns/1ps

module rp_top_4adc
  import rp_pkg::*;
(
  input  logic                adc_clk_01,   // single core clock
  input  logic                rst_i,
  // converter
  input  adc_raw_t    [4-1:0] adc_raw_i,    // parallel raw words
  output adc_sample_t [4-1:0] adc_dat_o,    // two's complement samples
  // system bus
  input  sys_addr_t           sys_addr_i,
  input  sys_data_t           sys_wdata_i,
  input  logic                sys_wen_i,
  input  logic                sys_ren_i,
  output sys_data_t           sys_rdata_o,
  output logic                sys_err_o,
  output logic                sys_ack_o,
  // board outputs
  output led_t                led_o,
  output logic        [4-1:0] pdm_o         // 1 bit pdm dacs
);

localparam int unsigned NUM_CH = 4;

sys_bus_if bus_up  ();  // from the bus master
sys_bus_if bus_hk  ();  // region 0
sys_bus_if bus_adc ();  // region 1
sys_bus_if bus_ams ();  // region 2

// plain ports onto the upstream bus
assign bus_up.addr  = sys_addr_i;
assign bus_up.wdata = sys_wdata_i;
assign bus_up.wen   = sys_wen_i;
assign bus_up.ren   = sys_ren_i;

assign sys_rdata_o = bus_up.rdata;
assign sys_err_o   = bus_up.err;
assign sys_ack_o   = bus_up.ack;

//////////////////////////////////////////////////////////////////////
// bus decoder
//////////////////////////////////////////////////////////////////////

sys_bus_decoder i_decoder (
  .adc_clk_01 (adc_clk_01),
  .rst_i      (rst_i     ),
  .bus_up     (bus_up    ),
  .bus_hk     (bus_hk    ),
  .bus_adc    (bus_adc   ),
  .bus_ams    (bus_ams   )
);

//////////////////////////////////////////////////////////////////////
// slaves
//////////////////////////////////////////////////////////////////////

adc_frontend #(.NUM_CH (NUM_CH)) i_adc (
  .adc_clk_01 (adc_clk_01),
  .rst_i      (rst_i     ),
  .adc_raw_i  (adc_raw_i ),
  .adc_dat_o  (adc_dat_o ),  // 2 cycles after raw
  .bus        (bus_adc   )
);

hk_regs i_hk (
  .adc_clk_01 (adc_clk_01),
  .rst_i      (rst_i     ),
  .bus        (bus_hk    ),
  .led_o      (led_o     )
);

ams_pdm #(.NUM_CH (NUM_CH)) i_ams (
  .adc_clk_01 (adc_clk_01),
  .rst_i      (rst_i     ),
  .bus        (bus_ams   ),
  .pdm_o      (pdm_o     )
);

endmodule: rp_top_4adc

/* verification/tb_rp_top_4adc.sv */
`timescale 1ns/1ps

module tb_rp_top_4adc
  import rp_pkg::*;
();

localparam int NCH        = 4;
localparam int MAX_CYCLES = 3000;  // ~300 adc + 2x255 pdm + bus, with margin
localparam int ACK_LIMIT  = 8;     // cycles before a request counts as lost
localparam int CAT_ADC    = 0;
localparam int CAT_BUS    = 1;
localparam int CAT_PDM    = 2;

localparam sys_addr_t BASE_HK  = 32'h0000_0000;
localparam sys_addr_t BASE_ADC = 32'h0010_0000;
localparam sys_addr_t BASE_AMS = 32'h0020_0000;
localparam sys_addr_t BASE_UNM = 32'h0050_0000;  // region 5, no slave

logic                    adc_clk_01 = 1'b0;
logic                    rst_i;
adc_raw_t    [NCH-1:0]   adc_raw_i;
adc_sample_t [NCH-1:0]   adc_dat_o;
sys_addr_t               sys_addr_i;
sys_data_t               sys_wdata_i;
logic                    sys_wen_i;
logic                    sys_ren_i;
sys_data_t               sys_rdata_o;
logic                    sys_err_o;
logic                    sys_ack_o;
led_t                    led_o;
logic        [NCH-1:0]   pdm_o;

int          err_cnt [3] = '{0, 0, 0};  // adc, bus, pdm
int          cycle_cnt   = 0;
logic [31:0] lcg_state   = 32'd98;      // seed

rp_top_4adc i_rp_top_4adc (.*);

//////////////////////////////////////////////////////////////////////
// clock, timeout
//////////////////////////////////////////////////////////////////////

initial begin
  forever #20 adc_clk_01 = ~adc_clk_01;  // 40 ns
end

always @(posedge adc_clk_01) begin
  cycle_cnt <= cycle_cnt + 1;
  if (cycle_cnt >= MAX_CYCLES) begin
    $display("simulation stopped, no result after %0d cycles", MAX_CYCLES);
    $display("errors adc %0d bus %0d pdm %0d", err_cnt[0], err_cnt[1], err_cnt[2]);
    $display("TESTS FAILED");
    $finish;
  end
end

//////////////////////////////////////////////////////////////////////
// helpers and reference models
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// offset binary with negative slope -> two's complement
function automatic adc_sample_t conv_ref(input adc_raw_t raw);
  return adc_sample_t'(raw ^ 14'h1fff);  // msb stays, rest flips
endfunction

// ones in a window that spans whole modulator periods
function automatic int pdm_ones_ref(input int setting, input int ncycles);
  return setting * (ncycles / PDM_RANGE);
endfunction

task automatic report_value(input int cat, input string sig, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
  $display("error at time %0t: %s expected %h got %h", $time, sig, exp_v, act_v);
  err_cnt[cat]++;
endtask

// ack is due at the negedge right after the request edge
task automatic wait_ack(input sys_addr_t addr, output sys_data_t rdata, output logic err);
  int waited;
  waited = 0;
  @(negedge adc_clk_01);
  while (!sys_ack_o && waited < ACK_LIMIT) begin
    @(negedge adc_clk_01);
    waited++;
  end
  rdata = sys_rdata_o;
  err   = sys_err_o;
  if (!sys_ack_o) begin
    $display("bus request to address %h was never acknowledged", addr);
    err_cnt[CAT_BUS]++;
  end else if (waited != 0) begin
    $display("bus request to address %h acknowledged %0d cycles late", addr, waited);
    err_cnt[CAT_BUS]++;
  end
endtask

task automatic bus_write(input sys_addr_t addr, input sys_data_t data,
                         output sys_data_t rdata, output logic err);
  @(posedge adc_clk_01);
  sys_addr_i  <= addr;
  sys_wdata_i <= data;
  sys_wen_i   <= 1'b1;
  @(posedge adc_clk_01);
  sys_wen_i   <= 1'b0;  // one cycle pulse
  wait_ack(addr, rdata, err);
endtask

task automatic bus_read(input sys_addr_t addr, output sys_data_t data, output logic err);
  @(posedge adc_clk_01);
  sys_addr_i <= addr;
  sys_ren_i  <= 1'b1;
  @(posedge adc_clk_01);
  sys_ren_i  <= 1'b0;
  wait_ack(addr, data, err);
endtask

//////////////////////////////////////////////////////////////////////
// adc compare process, runs for the whole test
//////////////////////////////////////////////////////////////////////

adc_raw_t [NCH-1:0] raw_d1;
adc_raw_t [NCH-1:0] raw_d2;
int                 valid_cnt;

always @(negedge adc_clk_01) begin
  if (rst_i) begin
    valid_cnt = 0;
  end else begin
    if (valid_cnt >= 2) begin  // pipeline filled
      for (int ch = 0; ch < NCH; ch++) begin
        if (adc_dat_o[ch] !== conv_ref(raw_d2[ch])) begin
          report_value(CAT_ADC, $sformatf("adc_dat_o[%0d]", ch),
                       32'(conv_ref(raw_d2[ch])), 32'(adc_dat_o[ch]));
        end
      end
    end
    if (valid_cnt < 2) valid_cnt++;
  end
  raw_d2 = raw_d1;  // raw word two cycles back
  raw_d1 = adc_raw_i;
end

//////////////////////////////////////////////////////////////////////
// stimulus
//////////////////////////////////////////////////////////////////////

initial begin
  logic [31:0] rnd;
  sys_data_t   rdata;
  logic        err;
  led_t        led_val;
  pdm_cfg_t    cfg [NCH];
  int          ones [NCH];

  rst_i       = 1'b1;
  adc_raw_i   = '0;
  sys_addr_i  = '0;
  sys_wdata_i = '0;
  sys_wen_i   = 1'b0;
  sys_ren_i   = 1'b0;

  // 5 reset edges, outputs checked during the last one
  repeat (4) @(posedge adc_clk_01);
  @(negedge adc_clk_01);
  if (sys_ack_o !== 1'b0) report_value(CAT_BUS, "sys_ack_o", 0, 32'(sys_ack_o));
  if (sys_err_o !== 1'b0) report_value(CAT_BUS, "sys_err_o", 0, 32'(sys_err_o));
  if (led_o !== '0) report_value(CAT_BUS, "led_o", 0, 32'(led_o));
  if (pdm_o !== '0) report_value(CAT_PDM, "pdm_o", 0, 32'(pdm_o));
  for (int ch = 0; ch < NCH; ch++) begin
    if (adc_dat_o[ch] !== '0) begin
      report_value(CAT_ADC, $sformatf("adc_dat_o[%0d]", ch), 0, 32'(adc_dat_o[ch]));
    end
  end
  @(posedge adc_clk_01);
  rst_i <= 1'b0;

  // random raw words, compare process does the checking
  repeat (300) begin
    @(posedge adc_clk_01);
    for (int ch = 0; ch < NCH; ch++) begin
      rnd = lcg_next();
      adc_raw_i[ch] <= rnd[31:18];
    end
  end

  // housekeeping id and led
  bus_read(BASE_HK, rdata, err);
  if (rdata !== HK_ID) report_value(CAT_BUS, "sys_rdata_o", HK_ID, rdata);
  if (err !== 1'b0) report_value(CAT_BUS, "sys_err_o", 0, 32'(err));
  rnd     = lcg_next();
  led_val = rnd[31:24];
  bus_write(BASE_HK + 32'h4, 32'(led_val), rdata, err);
  if (led_o !== led_val) report_value(CAT_BUS, "led_o", 32'(led_val), 32'(led_o));
  bus_read(BASE_HK + 32'h4, rdata, err);
  if (rdata !== 32'(led_val)) report_value(CAT_BUS, "sys_rdata_o", 32'(led_val), rdata);

  // sample readback, raw held steady from here on
  repeat (3) @(posedge adc_clk_01);
  for (int ch = 0; ch < NCH; ch++) begin
    bus_read(BASE_ADC + 32'(ch * 4), rdata, err);
    if (rdata !== 32'(signed'(conv_ref(adc_raw_i[ch])))) begin
      report_value(CAT_BUS, "sys_rdata_o", 32'(signed'(conv_ref(adc_raw_i[ch]))), rdata);
    end
    if (err !== 1'b0) report_value(CAT_BUS, "sys_err_o", 0, 32'(err));
  end

  // pdm settings: both ends plus two distinct random values
  rnd    = lcg_next();
  cfg[0] = 8'd0;
  cfg[1] = 8'd255;
  cfg[2] = pdm_cfg_t'(1 + rnd[31:16] % 254);
  rnd    = lcg_next();
  cfg[3] = pdm_cfg_t'(1 + rnd[31:16] % 254);
  if (cfg[3] == cfg[2]) cfg[3] = (cfg[2] == 8'd254) ? 8'd1 : cfg[2] + 8'd1;
  for (int ch = 0; ch < NCH; ch++) begin
    bus_write(BASE_AMS + 32'(ch * 4), 32'(cfg[ch]), rdata, err);
  end
  for (int ch = 0; ch < NCH; ch++) begin
    bus_read(BASE_AMS + 32'(ch * 4), rdata, err);
    if (rdata !== 32'(cfg[ch])) report_value(CAT_PDM, "sys_rdata_o", 32'(cfg[ch]), rdata);
    if (err !== 1'b0) report_value(CAT_BUS, "sys_err_o", 0, 32'(err));
  end

  // two windows at different phases
  for (int win = 0; win < 2; win++) begin
    repeat (7 * win + 1) @(negedge adc_clk_01);
    ones = '{0, 0, 0, 0};
    repeat (PDM_RANGE) begin
      @(negedge adc_clk_01);
      for (int ch = 0; ch < NCH; ch++) ones[ch] += pdm_o[ch];
    end
    for (int ch = 0; ch < NCH; ch++) begin
      if (ones[ch] != pdm_ones_ref(cfg[ch], PDM_RANGE)) begin
        report_value(CAT_PDM, $sformatf("pdm_o[%0d] ones", ch),
                     pdm_ones_ref(cfg[ch], PDM_RANGE), ones[ch]);
      end
    end
  end

  // unmapped region answers with err
  bus_read(BASE_UNM + 32'h8, rdata, err);
  if (err !== 1'b1) report_value(CAT_BUS, "sys_err_o", 1, 32'(err));
  if (rdata !== '0) report_value(CAT_BUS, "sys_rdata_o", 0, rdata);
  bus_write(BASE_UNM, 32'hdead_beef, rdata, err);
  if (err !== 1'b1) report_value(CAT_BUS, "sys_err_o", 1, 32'(err));
  if (rdata !== '0) report_value(CAT_BUS, "sys_rdata_o", 0, rdata);

  repeat (2) @(posedge adc_clk_01);
  $display("errors adc %0d bus %0d pdm %0d", err_cnt[0], err_cnt[1], err_cnt[2]);
  if (err_cnt[0] + err_cnt[1] + err_cnt[2] == 0) begin
    $display("TESTS PASSED");
  end else begin
    $display("TESTS FAILED");
  end
  $finish;
end

endmodule: tb_rp_top_4adc

/* rp_top_4adc.f */
source/rp_pkg.sv
source/sys_bus_if.sv
source/sys_bus_decoder.sv
source/adc_frontend.sv
source/hk_regs.sv
source/ams_pdm.sv
source/rp_top_4adc.sv
verification/tb_rp_top_4adc.sv

/* Bender.yml */
package:
  name: rp_top_4adc

sources:
  - files:
      - source/rp_pkg.sv
      - source/sys_bus_if.sv
      - source/sys_bus_decoder.sv
      - source/adc_frontend.sv
      - source/hk_regs.sv
      - source/ams_pdm.sv
      - source/rp_top_4adc.sv
  - target: test
    files:
      - verification/tb_rp_top_4adc.sv
